// ==== tb.f ====
verilog/gat_pkg.sv
verilog/coef_rd_if.sv
verilog/dmvm_pipe.sv
verilog/coef_fifo.sv
verilog/coef_wb_slave.sv
verilog/attn_coef_top.sv
bench/attn_coef_tb.sv

// ==== Makefile ====
TOP = attn_coef_tb

# Build and run, a failing run exits non-zero through $fatal
sim:
	verilator --binary --timing --top-module $(TOP) -f tb.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

.PHONY: sim clean

// ==== bench/attn_coef_tb.sv ====
`default_nettype none

module attn_coef_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_FEAT   = 8;
  localparam int FIFO_DEPTH = 16;
  localparam int NUM_WGT    = 2 * NUM_FEAT;
  localparam int P1_WORDS   = 12;
  localparam int P2_WORDS   = FIFO_DEPTH + 6;
  localparam int NUM_WORDS  = P1_WORDS + P2_WORDS;
  localparam int TIMEOUT    = 40 * (NUM_WORDS + FIFO_DEPTH);

  typedef gat_pkg::wh_elem_t [NUM_FEAT-1:0] wh_word_t;

  logic             clk;
  logic             rst_n;
  logic             wb_cyc_i;
  logic             wb_stb_i;
  logic             wb_we_i;
  gat_pkg::wb_adr_t wb_adr_i;
  gat_pkg::wb_dat_t wb_dat_i;
  gat_pkg::wb_dat_t wb_dat_o;
  logic             wb_ack_o;
  logic             wh_vld_i;
  logic             wh_src_i;
  wh_word_t         wh_data_i;
  logic             wh_rdy_o;

  // Stimulus, weights and model results
  gat_pkg::coef_t   wgt_tab [NUM_WGT];
  wh_word_t         wh_tab  [NUM_WORDS];
  logic             src_tab [NUM_WORDS];
  gat_pkg::coef_t   exp_tab [NUM_WORDS];

  int               seed = 52;
  int               cycles = 0;
  logic             saw_stall;

  attn_coef_top #(
    .NUM_FEAT   (NUM_FEAT),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .wb_cyc_i   (wb_cyc_i),
    .wb_stb_i   (wb_stb_i),
    .wb_we_i    (wb_we_i),
    .wb_adr_i   (wb_adr_i),
    .wb_dat_i   (wb_dat_i),
    .wb_dat_o   (wb_dat_o),
    .wb_ack_o   (wb_ack_o),
    .wh_vld_i   (wh_vld_i),
    .wh_src_i   (wh_src_i),
    .wh_data_i  (wh_data_i),
    .wh_rdy_o   (wh_rdy_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT) begin
      $display("Timeout after %0d cycles, the DUT stopped making progress", cycles);
      abort_run();
    end
  end

  // ========================================
  // Checks
  // ========================================

  task automatic abort_run();
    $display("Simulation failed");
    $fatal(1, "Run stopped at the first failure");
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("** Error at %0d ns: %s is %b, expected %b", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_coef(input gat_pkg::coef_t got, input gat_pkg::coef_t exp,
                            input string what);
    if (got !== exp) begin
      $display("** Error at %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_word(input gat_pkg::wb_dat_t got, input gat_pkg::wb_dat_t exp,
                            input string what);
    if (got !== exp) begin
      $display("** Error at %0d ns: %s is 0x%h, expected 0x%h", $time, what, got, exp);
      abort_run();
    end
  endtask

  // ========================================
  // Stimulus and reference model
  // ========================================

  function automatic wh_word_t random_word();
    wh_word_t w;
    for (int j = 0; j < NUM_FEAT; j++) begin
      w[j] = gat_pkg::wh_elem_t'($random(seed));
    end
    return w;
  endfunction

  // Elements follow the weight signs, so a negative magnitude drives both dots down
  function automatic wh_word_t aligned_word(input int mag);
    wh_word_t w;
    for (int j = 0; j < NUM_FEAT; j++) begin
      w[j] = (wgt_tab[j] < 0) ? gat_pkg::wh_elem_t'(-mag) : gat_pkg::wh_elem_t'(mag);
    end
    return w;
  endfunction

  task automatic build_stimulus();
    // Source and neighbour weight share the sign of each feature
    wgt_tab = '{8'sd100, -8'sd90, 8'sd80, -8'sd70, 8'sd60, -8'sd50, 8'sd40, -8'sd30,
                8'sd50, -8'sd45, 8'sd120, -8'sd20, 8'sd90, -8'sd110, 8'sd35, -8'sd60};
    for (int i = 0; i < NUM_WORDS; i++) begin
      wh_tab[i]  = random_word();
      src_tab[i] = (i < P1_WORDS) ? (i % 4 == 0) : ((i - P1_WORDS) % 7 == 0);
    end
    // Subgraph one starts high, subgraph two is driven negative
    wh_tab[0] = aligned_word(2047);
    wh_tab[4] = aligned_word(-2000);
    wh_tab[5] = aligned_word(-1500);
    wh_tab[6] = aligned_word(-1000);
  endtask

  task automatic compute_expected(output int neg_cnt);
    int             src_dot;
    int             nbr_dot;
    int             held;
    int             shifted;
    gat_pkg::coef_t coef;
    held    = 0;
    neg_cnt = 0;
    for (int i = 0; i < NUM_WORDS; i++) begin
      src_dot = 0;
      nbr_dot = 0;
      for (int j = 0; j < NUM_FEAT; j++) begin
        src_dot += int'(wgt_tab[j]) * int'(wh_tab[i][j]);
        nbr_dot += int'(wgt_tab[NUM_FEAT+j]) * int'(wh_tab[i][j]);
      end
      if (src_tab[i]) begin
        held = src_dot;
      end
      shifted = (held + nbr_dot) >>> gat_pkg::COEF_SHIFT;
      coef    = gat_pkg::coef_t'(shifted);
      if (coef < 0) begin
        coef = '0;
        if (i < P1_WORDS) begin
          neg_cnt++;
        end
      end
      exp_tab[i] = coef;
    end
  endtask

  // ========================================
  // Bus and stream tasks
  // ========================================

  task automatic wb_write(input gat_pkg::wb_adr_t adr, input gat_pkg::wb_dat_t dat);
    @(negedge clk);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = 1'b1;
    wb_adr_i = adr;
    wb_dat_i = dat;
    @(negedge clk);
    while (!wb_ack_o) @(negedge clk);
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic wb_read(input gat_pkg::wb_adr_t adr, output gat_pkg::wb_dat_t dat);
    @(negedge clk);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = 1'b0;
    wb_adr_i = adr;
    @(negedge clk);
    while (!wb_ack_o) @(negedge clk);
    dat      = wb_dat_o;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
  endtask

  // Ready depends only on registers, so its falling-edge value decides the next accept
  task automatic stream_words(input int first, input int count);
    int i;
    i = first;
    while (i < first + count) begin
      @(negedge clk);
      wh_vld_i  = 1'b1;
      wh_src_i  = src_tab[i];
      wh_data_i = wh_tab[i];
      if (wh_rdy_o) begin
        i++;
      end else begin
        saw_stall = 1'b1;
      end
    end
    @(negedge clk);
    wh_vld_i = 1'b0;
  endtask

  // Empty reads are retried while words are still in the pipeline
  task automatic pop_and_check(input int first, input int count);
    gat_pkg::wb_dat_t d;
    int               i;
    i = first;
    while (i < first + count) begin
      wb_read(gat_pkg::ADDR_COEF, d);
      if (d[gat_pkg::COEF_VLD_BIT]) begin
        check_coef(gat_pkg::coef_t'(d[gat_pkg::COEF_W-1:0]), exp_tab[i],
                   $sformatf("coefficient %0d", i));
        i++;
      end
    end
  endtask

  // ========================================
  // Test sequence
  // ========================================

  initial begin : main_seq
    gat_pkg::wb_dat_t rd_dat;
    int               neg_cnt;
    rst_n     = 1'b0;
    wb_cyc_i  = 1'b0;
    wb_stb_i  = 1'b0;
    wb_we_i   = 1'b0;
    wb_adr_i  = '0;
    wb_dat_i  = '0;
    wh_vld_i  = 1'b0;
    wh_src_i  = 1'b0;
    wh_data_i = '0;
    saw_stall = 1'b0;

    build_stimulus();
    compute_expected(neg_cnt);
    if (neg_cnt == 0) begin
      $display("Stimulus has no negative sums in the subgraph phase");
      abort_run();
    end

    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Idle state after reset
    @(negedge clk);
    check_flag(wb_ack_o, 1'b0, "wb_ack_o after reset");
    check_flag(wh_rdy_o, 1'b1, "wh_rdy_o after reset");
    wb_read(gat_pkg::ADDR_STATUS, rd_dat);
    check_word(rd_dat, '0, "STATUS after reset");
    wb_read(gat_pkg::ADDR_COEF, rd_dat);
    check_flag(rd_dat[gat_pkg::COEF_VLD_BIT], 1'b0, "valid bit of empty pop");

    // Only the low byte of a weight write is kept
    for (int i = 0; i < NUM_WGT; i++) begin
      wb_write(gat_pkg::wb_adr_t'(i), {24'hA5A5A5, wgt_tab[i]});
    end
    for (int i = 0; i < NUM_WGT; i++) begin
      wb_read(gat_pkg::wb_adr_t'(i), rd_dat);
      check_word(rd_dat, {{(gat_pkg::WB_DAT_W - gat_pkg::COEF_W){wgt_tab[i][7]}}, wgt_tab[i]},
                 $sformatf("weight %0d readback", i));
    end

    // Three subgraphs at full rate
    stream_words(0, P1_WORDS);
    check_flag(saw_stall, 1'b0, "stall while streaming the subgraphs");
    pop_and_check(0, P1_WORDS);

    // Overfill with no reads until the FIFO is full
    fork
      stream_words(P1_WORDS, P2_WORDS);
      begin
        wait (saw_stall);
        wb_read(gat_pkg::ADDR_STATUS, rd_dat);
        while (rd_dat != gat_pkg::wb_dat_t'(FIFO_DEPTH)) begin
          wb_read(gat_pkg::ADDR_STATUS, rd_dat);
        end
        check_flag(wh_rdy_o, 1'b0, "wh_rdy_o with a full FIFO");
        pop_and_check(P1_WORDS, P2_WORDS);
      end
    join

    wb_read(gat_pkg::ADDR_STATUS, rd_dat);
    check_word(rd_dat, '0, "STATUS after draining");
    wb_read(gat_pkg::ADDR_COEF, rd_dat);
    check_flag(rd_dat[gat_pkg::COEF_VLD_BIT], 1'b0, "valid bit after draining");

    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/attn_coef_top.sv ====
`default_nettype none

module attn_coef_top #(
  parameter int NUM_FEAT   = 8,
  parameter int FIFO_DEPTH = 16
) (
  input  logic                             clk,
  input  logic                             rst_n,

  // Host Wishbone port
  input  logic                             wb_cyc_i,
  input  logic                             wb_stb_i,
  input  logic                             wb_we_i,
  input  gat_pkg::wb_adr_t                 wb_adr_i,
  input  gat_pkg::wb_dat_t                 wb_dat_i,
  output gat_pkg::wb_dat_t                 wb_dat_o,
  output logic                             wb_ack_o,

  // Wh node vectors
  input  logic                             wh_vld_i,
  input  logic                             wh_src_i,
  input  gat_pkg::wh_elem_t [NUM_FEAT-1:0] wh_data_i,
  output logic                             wh_rdy_o
);

  gat_pkg::coef_t [2*NUM_FEAT-1:0] weights;
  logic                            coef_wr_en;
  gat_pkg::coef_t                  coef_wr_data;

  coef_rd_if #(.FIFO_DEPTH(FIFO_DEPTH)) coef_if ();

  // ========================================
  // Datapath
  // ========================================

  dmvm_pipe #(
    .NUM_FEAT       (NUM_FEAT),
    .FIFO_DEPTH     (FIFO_DEPTH)
  ) i_dmvm_pipe (
    .clk            (clk),
    .rst_n          (rst_n),
    .weights_i      (weights),
    .wh_vld_i       (wh_vld_i),
    .wh_src_i       (wh_src_i),
    .wh_data_i      (wh_data_i),
    .wh_rdy_o       (wh_rdy_o),
    .fifo_level_i   (coef_if.level),
    .coef_wr_en_o   (coef_wr_en),
    .coef_wr_data_o (coef_wr_data)
  );

  coef_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_coef_fifo (
    .clk        (clk),
    .rst_n      (rst_n),
    .wr_en_i    (coef_wr_en),
    .wr_data_i  (coef_wr_data),
    .rd         (coef_if.fifo)
  );

  // Host access to weights and results
  coef_wb_slave #(
    .NUM_FEAT   (NUM_FEAT),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_coef_wb_slave (
    .clk        (clk),
    .rst_n      (rst_n),
    .wb_cyc_i   (wb_cyc_i),
    .wb_stb_i   (wb_stb_i),
    .wb_we_i    (wb_we_i),
    .wb_adr_i   (wb_adr_i),
    .wb_dat_i   (wb_dat_i),
    .wb_dat_o   (wb_dat_o),
    .wb_ack_o   (wb_ack_o),
    .weights_o  (weights),
    .rd         (coef_if.reader)
  );

endmodule

`default_nettype wire

// ==== verilog/coef_wb_slave.sv ====
`default_nettype none

module coef_wb_slave #(
  parameter int NUM_FEAT   = 8,
  parameter int FIFO_DEPTH = 16
) (
  input  logic                            clk,
  input  logic                            rst_n,

  // Wishbone classic slave
  input  logic                            wb_cyc_i,
  input  logic                            wb_stb_i,
  input  logic                            wb_we_i,
  input  gat_pkg::wb_adr_t                wb_adr_i,
  input  gat_pkg::wb_dat_t                wb_dat_i,
  output gat_pkg::wb_dat_t                wb_dat_o,
  output logic                            wb_ack_o,

  // Weight vector to the datapath
  output gat_pkg::coef_t [2*NUM_FEAT-1:0] weights_o,

  // Coefficient FIFO read side
  coef_rd_if.reader                       rd
);

  localparam int NUM_W = 2 * NUM_FEAT;
  localparam int IDX_W = $clog2(NUM_W);
  localparam int LVL_W = $clog2(FIFO_DEPTH) + 1;

  logic             wb_req;
  logic             wr_req;
  logic             rd_req;
  logic             hit_weight;
  logic             hit_coef;
  logic             hit_status;
  logic [IDX_W-1:0] wgt_idx;
  logic [LVL_W-1:0] fifo_level;
  gat_pkg::coef_t   weight_q [NUM_W];
  gat_pkg::wb_dat_t rd_word;

  // ========================================
  // Request and address decode
  // ========================================

  // Masked during the ack cycle so a held strobe is served once
  assign wb_req = wb_cyc_i && wb_stb_i && !wb_ack_o;
  assign wr_req = wb_req && wb_we_i;
  assign rd_req = wb_req && !wb_we_i;

  assign hit_weight = wb_adr_i < gat_pkg::wb_adr_t'(NUM_W);
  assign hit_coef   = (wb_adr_i == gat_pkg::ADDR_COEF);
  assign hit_status = (wb_adr_i == gat_pkg::ADDR_STATUS);
  assign wgt_idx    = wb_adr_i[IDX_W-1:0];
  assign fifo_level = rd.level;

  // Pop on the request edge, head is captured on the same edge
  assign rd.rd_en = rd_req && hit_coef && !rd.empty;

  // ========================================
  // Weight register file
  // ========================================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_W; i++) begin
        weight_q[i] <= '0;
      end
    end else if (wr_req && hit_weight) begin
      weight_q[wgt_idx] <= wb_dat_i[gat_pkg::COEF_W-1:0];
    end
  end

  always_comb begin
    for (int i = 0; i < NUM_W; i++) begin
      weights_o[i] = weight_q[i];
    end
  end

  // ========================================
  // Read data and ack
  // ========================================

  always_comb begin
    rd_word = '0;
    if (hit_weight) begin
      // Sign-extended weight
      rd_word = gat_pkg::wb_dat_t'(weight_q[wgt_idx]);
    end else if (hit_coef && !rd.empty) begin
      rd_word[gat_pkg::COEF_W-1:0]   = rd.rd_data;
      rd_word[gat_pkg::COEF_VLD_BIT] = 1'b1;
    end else if (hit_status) begin
      rd_word = gat_pkg::wb_dat_t'(fifo_level);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_ack_o <= 1'b0;
      wb_dat_o <= '0;
    end else begin
      wb_ack_o <= wb_req;
      if (rd_req) begin
        wb_dat_o <= rd_word;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/coef_fifo.sv ====
`default_nettype none

module coef_fifo #(
  parameter int FIFO_DEPTH = 16
) (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           wr_en_i,
  input  gat_pkg::coef_t wr_data_i,
  coef_rd_if.fifo        rd
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);

  gat_pkg::coef_t   mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;

  // ========================================
  // Storage
  // ========================================

  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      mem[wr_ptr] <= wr_data_i;
    end
  end

  // Pointers wrap naturally, depth is a power of two
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_en_i) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd.rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // Fill count, push and pop together leave it unchanged
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count <= '0;
    end else begin
      case ({wr_en_i, rd.rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Head entry is presented without a read request
  assign rd.rd_data = mem[rd_ptr];
  assign rd.empty   = (count == '0);
  assign rd.level   = count;

endmodule

`default_nettype wire

// ==== verilog/dmvm_pipe.sv ====
`default_nettype none

module dmvm_pipe #(
  parameter int NUM_FEAT   = 8,
  parameter int FIFO_DEPTH = 16
) (
  input  logic                               clk,
  input  logic                               rst_n,

  // Weight vector a, source half in the low indices
  input  gat_pkg::coef_t [2*NUM_FEAT-1:0]    weights_i,

  // Wh word stream
  input  logic                               wh_vld_i,
  input  logic                               wh_src_i,
  input  gat_pkg::wh_elem_t [NUM_FEAT-1:0]   wh_data_i,
  output logic                               wh_rdy_o,

  // Coefficient FIFO write side
  input  logic [$clog2(FIFO_DEPTH):0]        fifo_level_i,
  output logic                               coef_wr_en_o,
  output gat_pkg::coef_t                     coef_wr_data_o
);

  localparam int TREE_LVL = $clog2(NUM_FEAT);
  localparam int NODES    = 2 * NUM_FEAT - 1;
  localparam int LVL_W    = $clog2(FIFO_DEPTH) + 1;
  localparam int SUM_W    = gat_pkg::DOT_W + 1;

  logic                    wh_accept;

  // Heap-ordered adder trees, node k sums nodes 2k+1 and 2k+2
  gat_pkg::dot_t           src_tree [NODES];
  gat_pkg::dot_t           nbr_tree [NODES];

  logic [TREE_LVL:0]       vld_pipe;
  logic [TREE_LVL:0]       src_pipe;

  gat_pkg::dot_t           src_hold;
  gat_pkg::dot_t           src_dot;
  logic signed [SUM_W-1:0] coef_sum;
  logic signed [SUM_W-1:0] coef_shifted;
  gat_pkg::coef_t          coef_trunc;
  gat_pkg::coef_t          coef_relu;

  logic [LVL_W-1:0]        inflight;
  logic [LVL_W:0]          occupancy;

  assign wh_accept = wh_vld_i && wh_rdy_o;

  // ========================================
  // Multiply stage and adder tree
  // ========================================

  // Leaves hold the products, inner nodes add one level per clock
  always_ff @(posedge clk) begin
    for (int i = 0; i < NUM_FEAT; i++) begin
      src_tree[NUM_FEAT-1+i] <= gat_pkg::dot_t'($signed(weights_i[i]))
                                * gat_pkg::dot_t'(wh_data_i[i]);
      nbr_tree[NUM_FEAT-1+i] <= gat_pkg::dot_t'($signed(weights_i[NUM_FEAT+i]))
                                * gat_pkg::dot_t'(wh_data_i[i]);
    end
    for (int k = 0; k < NUM_FEAT - 1; k++) begin
      src_tree[k] <= src_tree[2*k+1] + src_tree[2*k+2];
      nbr_tree[k] <= nbr_tree[2*k+1] + nbr_tree[2*k+2];
    end
  end

  // Valid and source flag ride along with the tree levels
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_pipe <= '0;
      src_pipe <= '0;
    end else begin
      vld_pipe <= {vld_pipe[TREE_LVL-1:0], wh_accept};
      src_pipe <= {src_pipe[TREE_LVL-1:0], wh_src_i};
    end
  end

  // ========================================
  // Source latch and coefficient
  // ========================================

  // A flagged word uses its own source dot, others reuse the held one
  assign src_dot      = src_pipe[TREE_LVL] ? src_tree[0] : src_hold;
  assign coef_sum     = SUM_W'(src_dot) + SUM_W'(nbr_tree[0]);
  assign coef_shifted = coef_sum >>> gat_pkg::COEF_SHIFT;
  assign coef_trunc   = coef_shifted[gat_pkg::COEF_W-1:0];

  // ReLU on the 8-bit result
  assign coef_relu = coef_trunc[gat_pkg::COEF_W-1] ? '0 : coef_trunc;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      src_hold     <= '0;
      coef_wr_en_o <= 1'b0;
    end else begin
      coef_wr_en_o <= vld_pipe[TREE_LVL];
      if (vld_pipe[TREE_LVL] && src_pipe[TREE_LVL]) begin
        src_hold <= src_tree[0];
      end
    end
  end

  always_ff @(posedge clk) begin
    coef_wr_data_o <= coef_relu;
  end

  // ========================================
  // Flow control
  // ========================================

  // Words accepted but not yet written into the FIFO
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      inflight <= '0;
    end else begin
      case ({wh_accept, coef_wr_en_o})
        2'b10:   inflight <= inflight + 1'b1;
        2'b01:   inflight <= inflight - 1'b1;
        default: inflight <= inflight;
      endcase
    end
  end

  // Every accepted word has a FIFO slot reserved
  assign occupancy = {1'b0, inflight} + {1'b0, fifo_level_i};
  assign wh_rdy_o  = occupancy < (LVL_W + 1)'(FIFO_DEPTH);

endmodule

`default_nettype wire

// ==== verilog/coef_rd_if.sv ====
`default_nettype none

interface coef_rd_if #(
  parameter int FIFO_DEPTH = 16
);

  localparam int LVL_W = $clog2(FIFO_DEPTH) + 1;

  logic             rd_en;
  gat_pkg::coef_t   rd_data;
  logic             empty;
  logic [LVL_W-1:0] level;

  // Storage side
  modport fifo (
    input  rd_en,
    output rd_data,
    output empty,
    output level
  );

  // Bus side that pops entries
  modport reader (
    output rd_en,
    input  rd_data,
    input  empty,
    input  level
  );

endinterface

`default_nettype wire

// ==== verilog/gat_pkg.sv ====
`default_nettype none

package gat_pkg;

  // ========================================
  // Datapath widths
  // ========================================

  // Attention weights and output coefficients
  localparam int COEF_W     = 8;

  // One element of a transformed node vector
  localparam int WH_ELEM_W  = 12;

  // Dot sum width, enough for NUM_FEAT up to 32
  localparam int DOT_W      = 25;

  // Scaling from dot sum down to coefficient
  localparam int COEF_SHIFT = 17;

  typedef logic signed [COEF_W-1:0]    coef_t;
  typedef logic signed [WH_ELEM_W-1:0] wh_elem_t;
  typedef logic signed [DOT_W-1:0]     dot_t;

  // ========================================
  // Wishbone register map
  // ========================================

  localparam int WB_ADR_W = 8;
  localparam int WB_DAT_W = 32;

  typedef logic [WB_ADR_W-1:0] wb_adr_t;
  typedef logic [WB_DAT_W-1:0] wb_dat_t;

  // Word addresses 0 .. 2*NUM_FEAT-1 hold the weight vector a,
  // source half first, one weight in the low byte of each word

  // Reading this pops one coefficient
  localparam wb_adr_t ADDR_COEF   = 8'h40;

  // FIFO fill level
  localparam wb_adr_t ADDR_STATUS = 8'h41;

  // Set in a coefficient read when an entry was popped
  localparam int COEF_VLD_BIT = 8;

endpackage

`default_nettype wire
